// File: hdl/fdiv_pkg.sv
package fdiv_pkg;

  // binary32 field widths
  localparam int frac_w     = 23;
  localparam int mant_w     = 24;
  localparam int rem_w      = 28;
  localparam int num_digits = 8;
  localparam int exp_bias   = 127;
  localparam int tag_w      = 8;

  typedef struct packed {
    logic              sign;
    logic [7:0]        exp;
    logic [frac_w-1:0] frac;
  } fp32_t;

  typedef enum logic [2:0] {
    rm_trunc = 3'd0,
    rm_round = 3'd1,
    rm_even  = 3'd2,
    rm_plus  = 3'd3,
    rm_minus = 3'd4
  } rmode_e;

  typedef struct packed {
    fp32_t            a;
    fp32_t            b;
    rmode_e           rmode;
    logic [tag_w-1:0] tag;
  } div_req_t;

  typedef struct packed {
    fp32_t            value;
    logic [tag_w-1:0] tag;
  } div_res_t;

  // index d holds d times the divisor mantissa
  typedef logic [15:1][rem_w-1:0] multiples_t;

  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_iter = 2'd1,
    st_wait = 2'd2
  } ctrl_state_e;

endpackage

// File: hdl/fdiv_multiples.sv
`timescale 1ns/1ps

module fdiv_multiples import fdiv_pkg::*; (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              load,
  input  logic [mant_w-1:0] divisor,
  output multiples_t        multiples
);

  logic [rem_w-1:0] m1, m3, m5, m7, m9, m11, m13, m15;
  multiples_t       mult_d;

  assign m1 = {{(rem_w - mant_w){1'b0}}, divisor};

  // odd multiples by shift and add
  assign m3  = m1 + (m1 << 1);
  assign m5  = m1 + (m1 << 2);
  assign m7  = m3 + (m1 << 2);
  assign m9  = m1 + (m1 << 3);
  assign m11 = m3 + (m1 << 3);
  assign m13 = m5 + (m1 << 3);
  assign m15 = m7 + (m1 << 3);

  // even ones are shifts of smaller multiples
  always_comb begin
    mult_d[1]  = m1;
    mult_d[2]  = m1 << 1;
    mult_d[3]  = m3;
    mult_d[4]  = m1 << 2;
    mult_d[5]  = m5;
    mult_d[6]  = m3 << 1;
    mult_d[7]  = m7;
    mult_d[8]  = m1 << 3;
    mult_d[9]  = m9;
    mult_d[10] = m5 << 1;
    mult_d[11] = m11;
    mult_d[12] = m3 << 2;
    mult_d[13] = m13;
    mult_d[14] = m7 << 1;
    mult_d[15] = m15;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      multiples <= '0;
    end else if (load) begin
      multiples <= mult_d;
    end
  end

endmodule

// File: hdl/fdiv_digit_select.sv
`timescale 1ns/1ps

module fdiv_digit_select import fdiv_pkg::*; (
  input  logic [rem_w-1:0] remainder,
  input  multiples_t       multiples,
  output logic [3:0]       digit,
  output logic [rem_w-1:0] next_remainder
);

  logic [rem_w-1:0]       shifted;
  logic [15:1][rem_w:0]   diff;

  // top nibble is zero once the recurrence runs, so this is the shift by four.
  // on the first step it holds the dividend's low nibble and brings it back in
  assign shifted = {remainder[rem_w-5:0], remainder[rem_w-1:rem_w-4]};

  // all fifteen trial subtractions in parallel
  always_comb begin
    for (int d = 1; d < 16; d++) begin
      diff[d] = {1'b0, shifted} - {1'b0, multiples[d]};
    end
  end

  // multiples grow with d, last non-negative one wins
  always_comb begin
    digit          = 4'd0;
    next_remainder = shifted;
    for (int d = 1; d < 16; d++) begin
      if (!diff[d][rem_w]) begin
        digit          = 4'(d);
        next_remainder = diff[d][rem_w-1:0];
      end
    end
  end

endmodule

// File: hdl/fdiv_recurrence.sv
`timescale 1ns/1ps

module fdiv_recurrence import fdiv_pkg::*; (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    start,
  input  div_req_t                req,
  output logic                    rdy,
  output logic                    load,
  output logic [mant_w-1:0]       divisor,
  output logic [rem_w-1:0]        remainder,
  input  logic [3:0]              digit,
  input  logic [rem_w-1:0]        next_remainder,
  output logic                    done,
  output logic [4*num_digits-1:0] quotient,
  output logic                    sticky,
  output div_req_t                req_q,
  input  logic                    taken
);

  ctrl_state_e                     state;
  logic [$clog2(num_digits)-1:0]   cnt;
  logic                            accept;
  logic                            step;
  logic [mant_w-1:0]               mant_a;

  assign accept = (state == st_idle) && start && rdy;
  // first iter cycle waits for the multiples register
  assign step   = (state == st_iter) && !load;

  assign mant_a  = {1'b1, req.a.frac};
  assign divisor = {1'b1, req_q.b.frac};
  assign sticky  = |remainder;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= st_idle;
      rdy   <= 1'b1;
      load  <= 1'b0;
      done  <= 1'b0;
      cnt   <= '0;
    end else begin
      load <= 1'b0;
      done <= 1'b0;
      case (state)
        st_idle: begin
          if (accept) begin
            state <= st_iter;
            rdy   <= 1'b0;
            load  <= 1'b1;
            cnt   <= '0;
          end
        end
        st_iter: begin
          if (step) begin
            cnt <= cnt + 1'b1;
            if (cnt == ($clog2(num_digits))'(num_digits - 1)) begin
              state <= st_wait;
              done  <= 1'b1;
            end
          end
        end
        st_wait: begin
          if (taken) begin
            state <= st_idle;
            rdy   <= 1'b1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // dividend over sixteen, low nibble parked in the top bits
  always_ff @(posedge clk) begin
    if (accept) begin
      req_q     <= req;
      remainder <= {mant_a[3:0], 4'b0000, mant_a[mant_w-1:4]};
      quotient  <= '0;
    end else if (step) begin
      remainder <= next_remainder;
      quotient  <= {quotient[4*num_digits-5:0], digit};
    end
  end

endmodule

// File: hdl/fdiv_round.sv
`timescale 1ns/1ps

module fdiv_round import fdiv_pkg::*; (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    done,
  input  logic [4*num_digits-1:0] quotient,
  input  logic                    sticky,
  input  div_req_t                req_q,
  input  logic                    out_ready,
  output logic                    out_valid,
  output div_res_t                res,
  output logic                    taken
);

  logic              lead;
  logic [mant_w-1:0] mant;
  logic              rnd_bit;
  logic              tail;
  logic              sign;
  logic              inc;
  logic [mant_w:0]   mant_rnd;
  logic [7:0]        exp_diff;
  logic [7:0]        exp_norm;
  div_res_t          res_d;

  // bit 28 is the integer part of the quotient
  assign lead    = quotient[28];
  assign mant    = lead ? quotient[28:5] : quotient[27:4];
  assign rnd_bit = lead ? quotient[4] : quotient[3];
  assign tail    = (lead ? |quotient[3:0] : |quotient[2:0]) | sticky;
  assign sign    = req_q.a.sign ^ req_q.b.sign;

  assign exp_diff = req_q.a.exp - req_q.b.exp + 8'(exp_bias);
  assign exp_norm = lead ? exp_diff : exp_diff - 8'd1;

  always_comb begin
    case (req_q.rmode)
      rm_round: inc = rnd_bit;
      rm_even:  inc = rnd_bit && (tail || mant[0]);
      rm_plus:  inc = !sign && (rnd_bit || tail);
      rm_minus: inc = sign && (rnd_bit || tail);
      default:  inc = 1'b0;
    endcase
  end

  // carry out leaves a zero fraction, exponent goes up by one
  assign mant_rnd = {1'b0, mant} + {{mant_w{1'b0}}, inc};

  always_comb begin
    res_d.value.sign = sign;
    res_d.value.exp  = exp_norm + {7'd0, mant_rnd[mant_w]};
    res_d.value.frac = mant_rnd[frac_w-1:0];
    res_d.tag        = req_q.tag;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
      taken     <= 1'b0;
    end else begin
      taken <= out_valid && out_ready;
      if (done) begin
        out_valid <= 1'b1;
      end else if (out_ready) begin
        out_valid <= 1'b0;
      end
    end
  end

  // only loads on done, so held while stalled
  always_ff @(posedge clk) begin
    if (done) begin
      res <= res_d;
    end
  end

endmodule

// File: hdl/fdiv_top.sv
`timescale 1ns/1ps

module fdiv_top import fdiv_pkg::*; (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     start,
  input  div_req_t req,
  output logic     rdy,
  output logic     out_valid,
  input  logic     out_ready,
  output div_res_t res
);

  logic                    load;
  logic [mant_w-1:0]       divisor;
  multiples_t              multiples;
  logic [rem_w-1:0]        remainder;
  logic [3:0]              digit;
  logic [rem_w-1:0]        next_remainder;
  logic                    done;
  logic [4*num_digits-1:0] quotient;
  logic                    sticky;
  div_req_t                req_q;
  logic                    taken;

  fdiv_recurrence u_recurrence (
    .clk            (clk),
    .arst_n         (arst_n),
    .start          (start),
    .req            (req),
    .rdy            (rdy),
    .load           (load),
    .divisor        (divisor),
    .remainder      (remainder),
    .digit          (digit),
    .next_remainder (next_remainder),
    .done           (done),
    .quotient       (quotient),
    .sticky         (sticky),
    .req_q          (req_q),
    .taken          (taken)
  );

  fdiv_multiples u_multiples (
    .clk       (clk),
    .arst_n    (arst_n),
    .load      (load),
    .divisor   (divisor),
    .multiples (multiples)
  );

  fdiv_digit_select u_digit_select (
    .remainder      (remainder),
    .multiples      (multiples),
    .digit          (digit),
    .next_remainder (next_remainder)
  );

  fdiv_round u_round (
    .clk       (clk),
    .arst_n    (arst_n),
    .done      (done),
    .quotient  (quotient),
    .sticky    (sticky),
    .req_q     (req_q),
    .out_ready (out_ready),
    .out_valid (out_valid),
    .res       (res),
    .taken     (taken)
  );

endmodule

// File: verif/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic arst_n
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // release just after the edge, clear of the DUT's sampling
  initial begin
    arst_n = 1'b0;
    repeat (8) @(posedge clk);
    #1 arst_n = 1'b1;
  end

endmodule

// File: verif/tb_checker.sv
`timescale 1ns/1ps

module tb_checker import fdiv_pkg::*; (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     start,
  input  logic     rdy,
  input  logic     out_valid,
  input  logic     out_ready,
  input  div_res_t res,
  output int       checked,
  output int       errors
);

  localparam int valid_latency = 10;

  div_res_t expected[$];
  int       n_checked = 0;
  int       n_errors = 0;
  int       cycle = 0;
  int       accept_cycle = 0;
  logic     valid_q = 1'b0;
  logic     bad_latency = 1'b0;

  assign checked = n_checked;
  assign errors  = n_errors;

  initial begin
    int          fd;
    string       line;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] value;
    logic [2:0]  mode;
    logic [7:0]  tag;
    div_res_t    e;
    fd = $fopen("verif/fdiv_trace.txt", "r");
    if (fd != 0) begin
      while ($fgets(line, fd) > 0) begin
        // comment lines fail the hex scan and drop out here
        if ($sscanf(line, "%h %h %h %h %h", a, b, mode, tag, value) == 5) begin
          e.value = value;
          e.tag   = tag;
          expected.push_back(e);
        end
      end
      $fclose(fd);
    end
  end

  always @(posedge clk) begin
    div_res_t exp_res;
    int       latency;
    cycle = cycle + 1;
    if (arst_n) begin
      if (start && rdy) begin
        accept_cycle = cycle;
      end
      // high here means it went up on the previous edge
      if (out_valid && !valid_q) begin
        latency = cycle - 1 - accept_cycle;
        if (latency != valid_latency) begin
          $display("test %0d: out_valid rose %0d cycles after the request was accepted, not %0d",
                   n_checked + 1, latency, valid_latency);
          bad_latency = 1'b1;
        end
      end
      if (out_valid && out_ready) begin
        n_checked++;
        if (expected.size() == 0) begin
          $display("test %0d: a result arrived with no request left in the trace", n_checked);
          n_errors++;
        end else begin
          exp_res = expected.pop_front();
          if (res !== exp_res) begin
            $display("ERROR test %0d: res value %h tag %h, expected value %h tag %h",
                     n_checked, res.value, res.tag, exp_res.value, exp_res.tag);
            n_errors++;
          end else if (bad_latency) begin
            $display("test %0d failed: the result is right but out_valid rose at the wrong time",
                     n_checked);
            n_errors++;
          end else begin
            $display("test %0d passed: tag %h value %h", n_checked, res.tag, res.value);
          end
        end
        bad_latency = 1'b0;
      end
    end
    valid_q = out_valid;
  end

endmodule

// File: verif/fdiv_props.sv
`timescale 1ns/1ps

module fdiv_props import fdiv_pkg::*; (
  input logic     clk,
  input logic     arst_n,
  input logic     rdy,
  input logic     out_valid,
  input logic     out_ready,
  input div_res_t res
);

  valid_low_in_reset: assert property (@(posedge clk) !arst_n |-> !out_valid)
    else $error("out_valid high while in reset");

  // stalled result must not move
  stall_holds_result: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid && !out_ready |=> out_valid && $stable(res))
    else $error("result changed while stalled");

  one_op_in_flight: assert property (@(posedge clk) disable iff (!arst_n)
    !(rdy && out_valid))
    else $error("rdy and out_valid high together");

endmodule

bind fdiv_top fdiv_props u_props (
  .clk       (clk),
  .arst_n    (arst_n),
  .rdy       (rdy),
  .out_valid (out_valid),
  .out_ready (out_ready),
  .res       (res)
);

// File: verif/tb_top.sv
`timescale 1ns/1ps

module tb_top import fdiv_pkg::*; ();

  localparam int cycles_per_test = 40;

  logic        clk;
  logic        arst_n;
  logic        start = 1'b0;
  div_req_t    req = '0;
  logic        rdy;
  logic        out_valid;
  logic        out_ready = 1'b0;
  div_res_t    res;
  int          checked;
  int          errors;
  int          n_tests = 0;
  div_req_t    reqs[$];
  logic [31:0] lfsr = 32'd92201;

  tb_clk_gen u_clk_gen (
    .clk    (clk),
    .arst_n (arst_n)
  );

  fdiv_top u_dut (
    .clk       (clk),
    .arst_n    (arst_n),
    .start     (start),
    .req       (req),
    .rdy       (rdy),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .res       (res)
  );

  tb_checker u_checker (
    .clk       (clk),
    .arst_n    (arst_n),
    .start     (start),
    .rdy       (rdy),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .res       (res),
    .checked   (checked),
    .errors    (errors)
  );

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic load_requests();
    int          fd;
    string       line;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] value;
    logic [2:0]  mode;
    logic [7:0]  tag;
    div_req_t    r;
    fd = $fopen("verif/fdiv_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open verif/fdiv_trace.txt");
    end else begin
      while ($fgets(line, fd) > 0) begin
        if ($sscanf(line, "%h %h %h %h %h", a, b, mode, tag, value) == 5) begin
          r.a     = a;
          r.b     = b;
          r.rmode = rmode_e'(mode);
          r.tag   = tag;
          reqs.push_back(r);
        end
      end
      $fclose(fd);
    end
    n_tests = reqs.size();
  endtask

  task automatic send_request(input div_req_t r);
    @(posedge clk);
    #1;
    while (!rdy) begin
      @(posedge clk);
      #1;
    end
    start = 1'b1;
    req   = r;
    @(posedge clk);
    #1;
    start = 1'b0;
  endtask

  // random back-pressure, one bit per cycle
  always @(posedge clk) begin
    #1;
    lfsr      = lfsr_next(lfsr);
    out_ready = lfsr[0];
  end

  initial begin
    load_requests();
    wait (arst_n);
    foreach (reqs[i]) begin
      send_request(reqs[i]);
    end
    wait (checked >= n_tests);
    // room for a stray extra result to show up
    repeat (4) @(posedge clk);
    $display("%0d tests run, %0d passed, %0d failed", checked, checked - errors, errors);
    if (errors == 0 && n_tests > 0 && checked == n_tests) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    #1;
    repeat (n_tests * cycles_per_test + 24) @(posedge clk);
    $display("timed out with %0d of %0d results received", checked, n_tests);
    $display("Simulation failed");
    $finish;
  end

endmodule

// File: verif/fdiv_trace.txt
// columns: operand a, operand b, rounding mode, tag, expected result (all hex)
// modes: 0 truncate, 1 round half away, 2 round half even, 3 toward plus, 4 toward minus
40C00000 40400000 0 01 40000000
40C00000 40400000 3 02 40000000
3F800000 3E800000 4 03 40800000
3F800000 40400000 0 04 3EAAAAAA
3F800000 40400000 1 05 3EAAAAAB
3F800000 40400000 2 06 3EAAAAAB
3F800000 40400000 3 07 3EAAAAAB
3F800000 40400000 4 08 3EAAAAAA
BF800000 40400000 3 09 BEAAAAAA
BF800000 40400000 4 0A BEAAAAAB
3F800000 C0400000 1 0B BEAAAAAB
C0C00000 C0400000 4 0C 40000000
40A00000 40400000 3 0D 3FD55556
C0A00000 40400000 4 0E BFD55556
3FC00000 3FA00000 2 0F 3F99999A
BFC00000 3FA00000 3 10 BF999999
3F800000 40E00000 2 11 3E124925
3FFFFFFE 3FFFFFFF 0 12 3F7FFFFE
3FFFFFFE 3FFFFFFF 2 13 3F7FFFFF
41200000 40800000 1 14 40200000

// File: tb.f
hdl/fdiv_pkg.sv
hdl/fdiv_multiples.sv
hdl/fdiv_digit_select.sv
hdl/fdiv_recurrence.sv
hdl/fdiv_round.sv
hdl/fdiv_top.sv
verif/tb_clk_gen.sv
verif/tb_checker.sv
verif/fdiv_props.sv
verif/tb_top.sv

// File: run.sh
#!/bin/sh
# builds and runs the fdiv testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_top -f tb.f

./obj_dir/Vtb_top | tee sim.log

grep -q "Simulation completed successfully" sim.log
